/* hdl/fe_fetch_pipe.sv */
// fetch pipe with pc register, axi4-lite read master and in-flight epoch record
`timescale 1ns/1ps
`default_nettype none

`include "fe_defs.svh"

module fe_fetch_pipe (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset_n,
  input  wire fe_pkg::redirect_t     i_redirect,
  input  wire logic [`FE_CNT_W-1:0]  i_iq_count,
  // axi4-lite read address
  output logic                       o_arvalid,
  input  wire logic                  i_arready,
  output logic [`FE_XLEN-1:0]        o_araddr,
  output logic [2:0]                 o_arprot,
  // axi4-lite read data
  input  wire logic                  i_rvalid,
  output logic                       o_rready,
  input  wire logic [`FE_XLEN-1:0]   i_rdata,
  input  wire fe_pkg::axi_resp_e     i_rresp,
  // toward the instruction queue
  output logic                       o_push_valid,
  output fe_pkg::fe_inst_t           o_push
);

  localparam int PTR_W = $clog2(`FE_IQ_DEPTH);
  // unprivileged, secure, instruction access
  localparam logic [2:0] ARPROT_INST = 3'b100;

  // next pc to request
  logic [`FE_XLEN-1:0] r_pc;
  logic                r_epoch;
  // ar channel holding register
  logic                r_ar_valid;
  logic [`FE_XLEN-1:0] r_ar_addr;
  logic                r_ar_epoch;
  // in-order record of accepted reads
  logic [`FE_XLEN-1:0] r_fl_addr [`FE_IQ_DEPTH];
  logic                r_fl_epoch [`FE_IQ_DEPTH];
  logic [PTR_W-1:0]    r_fl_wr;
  logic [PTR_W-1:0]    r_fl_rd;
  logic [`FE_CNT_W-1:0] r_fl_cnt;
  // response stage
  logic                r_push_valid;
  fe_pkg::fe_inst_t    r_push;

  logic                w_ar_hs;
  logic                w_r_hs;
  logic [`FE_CNT_W:0]  w_used;
  logic                w_issue;
  logic [`FE_XLEN-1:0] w_next_addr;
  logic                w_next_epoch;
  logic                w_rsp_live;

  // ========================================================================
  // address side
  // ========================================================================

  assign w_ar_hs = r_ar_valid & i_arready;

  // every word that will still land in the queue
  // counts accepted reads, the pending ar, the response stage and queued words
  assign w_used = (`FE_CNT_W+1)'(r_fl_cnt) + (`FE_CNT_W+1)'(r_ar_valid)
                + (`FE_CNT_W+1)'(r_push_valid) + (`FE_CNT_W+1)'(i_iq_count);

  // load a new ar when the slot frees and a queue entry is still unclaimed
  assign w_issue = (~r_ar_valid | i_arready) & (w_used < (`FE_CNT_W+1)'(`FE_IQ_DEPTH));

  // a redirect in this cycle goes straight to the bus
  assign w_next_addr  = i_redirect.valid ? i_redirect.target : r_pc;
  assign w_next_epoch = r_epoch ^ i_redirect.valid;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_pc       <= `FE_PC_RESET;
      r_epoch    <= 1'b0;
      r_ar_valid <= 1'b0;
      r_ar_addr  <= `FE_PC_RESET;
      r_ar_epoch <= 1'b0;
    end else begin
      // old requests still in flight get dropped on return
      if (i_redirect.valid) begin
        r_epoch <= ~r_epoch;
      end
      if (w_issue) begin
        r_ar_valid <= 1'b1;
        r_ar_addr  <= w_next_addr;
        r_ar_epoch <= w_next_epoch;
        r_pc       <= w_next_addr + `FE_XLEN'(`FE_INST_B);
      end else begin
        if (w_ar_hs) begin
          r_ar_valid <= 1'b0;
        end
        // pending ar keeps its address while the target waits in the pc
        if (i_redirect.valid) begin
          r_pc <= i_redirect.target;
        end
      end
    end
  end

  // ========================================================================
  // in-flight record
  // ========================================================================

  // responses come back in order, so a plain fifo is enough
  assign w_r_hs = i_rvalid & o_rready;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_fl_wr  <= '0;
      r_fl_rd  <= '0;
      r_fl_cnt <= '0;
    end else begin
      if (w_ar_hs) begin
        r_fl_wr <= r_fl_wr + 1'b1;
      end
      if (w_r_hs) begin
        r_fl_rd <= r_fl_rd + 1'b1;
      end
      case ({w_ar_hs, w_r_hs})
        2'b10:   r_fl_cnt <= r_fl_cnt + 1'b1;
        2'b01:   r_fl_cnt <= r_fl_cnt - 1'b1;
        default: r_fl_cnt <= r_fl_cnt;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_ar_hs) begin
      r_fl_addr[r_fl_wr]  <= r_ar_addr;
      r_fl_epoch[r_fl_wr] <= r_ar_epoch;
    end
  end

  // ========================================================================
  // response side
  // ========================================================================

  // stale epoch, or a redirect landing this cycle, kills the word
  assign w_rsp_live = (r_fl_epoch[r_fl_rd] == r_epoch) & ~i_redirect.valid;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_push_valid <= 1'b0;
    end else begin
      r_push_valid <= w_r_hs & w_rsp_live;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_r_hs) begin
      r_push.pc    <= r_fl_addr[r_fl_rd];
      r_push.inst  <= i_rdata;
      r_push.fault <= (i_rresp != fe_pkg::OKAY);
    end
  end

  assign o_arvalid    = r_ar_valid;
  assign o_araddr     = r_ar_addr;
  assign o_arprot     = ARPROT_INST;
  // room for every read is reserved before issue
  assign o_rready     = 1'b1;
  assign o_push_valid = r_push_valid;
  assign o_push       = r_push;

endmodule

`default_nettype wire

/* hdl/fe_inst_queue.sv */
// instruction queue: circular buffer toward decode with flush and count
`timescale 1ns/1ps
`default_nettype none

`include "fe_defs.svh"

module fe_inst_queue (
  input  wire logic                 i_clk,
  input  wire logic                 i_reset_n,
  input  wire logic                 i_flush,
  input  wire logic                 i_push_valid,
  input  wire fe_pkg::fe_inst_t     i_push,
  output logic [`FE_CNT_W-1:0]      o_count,
  output logic                      o_inst_valid,
  output fe_pkg::fe_inst_t          o_inst,
  input  wire logic                 i_inst_ready
);

  localparam int PTR_W = $clog2(`FE_IQ_DEPTH);

  fe_pkg::fe_inst_t     r_mem [`FE_IQ_DEPTH];
  logic [PTR_W-1:0]     r_wr_ptr;
  logic [PTR_W-1:0]     r_rd_ptr;
  logic [`FE_CNT_W-1:0] r_count;
  logic                 w_pop;

  // decode takes the head
  assign w_pop = o_inst_valid & i_inst_ready;

  // ========================================================================
  // pointers and count
  // ========================================================================

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else if (i_flush) begin
      // redirect drops everything, including a push this cycle
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      // the pipe only pushes into reserved room
      if (i_push_valid) begin
        r_wr_ptr <= r_wr_ptr + 1'b1;
      end
      if (w_pop) begin
        r_rd_ptr <= r_rd_ptr + 1'b1;
      end
      case ({i_push_valid, w_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  // storage
  always_ff @(posedge i_clk) begin
    if (i_push_valid) begin
      r_mem[r_wr_ptr] <= i_push;
    end
  end

  // head straight from storage, so a word waits at least a cycle
  assign o_inst_valid = (r_count != '0);
  assign o_inst       = r_mem[r_rd_ptr];
  // credit back to the pipe
  assign o_count      = r_count;

endmodule

`default_nettype wire

/* hdl/fe_pkg.sv */
// fetch front end package: flush cause and axi response enums, bus structs
`default_nettype none

`include "fe_defs.svh"

package fe_pkg;

  // ========================================================================
  // enums
  // ========================================================================

  // commit flush kinds
  // trap codes follow the riscv mcause numbering,
  // so a code doubles as its medeleg bit index
  typedef enum logic [`FE_CAUSE_W-1:0] {
    INST_ACC_FAULT = 4'd1,
    ILLEGAL_INST   = 4'd2,
    LOAD_ACC_FAULT = 4'd5,
    ECALL_U        = 4'd8,
    ECALL_S        = 4'd9,
    ECALL_M        = 4'd11,
    // non-trap flushes sit above the trap codes
    SILENT_FLUSH   = 4'd12,
    ANOTHER_FLUSH  = 4'd13,
    MRET           = 4'd14,
    SRET           = 4'd15
  } flush_cause_e;

  // axi read response codes, exokay unused by fetch
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // ========================================================================
  // structs
  // ========================================================================

  // committed flush from the back end
  typedef struct packed {
    logic                valid;
    flush_cause_e        cause;
    logic [`FE_XLEN-1:0] epc;
  } commit_t;

  // resolved branch
  typedef struct packed {
    logic                valid;
    logic                mispredict;
    logic [`FE_XLEN-1:0] target;
  } br_upd_t;

  // trap related csr state
  typedef struct packed {
    logic [`FE_XLEN-1:0] mtvec;
    logic [`FE_XLEN-1:0] stvec;
    logic [`FE_XLEN-1:0] mepc;
    logic [`FE_XLEN-1:0] sepc;
    logic [`FE_XLEN-1:0] medeleg;
  } csr_t;

  // fetch redirect
  typedef struct packed {
    logic                valid;
    logic [`FE_XLEN-1:0] target;
  } redirect_t;

  // one fetched word toward decode
  typedef struct packed {
    logic [`FE_XLEN-1:0] pc;
    logic [`FE_XLEN-1:0] inst;
    logic                fault;
  } fe_inst_t;

endpackage

`default_nettype wire

/* hdl/fe_redirect_decode.sv */
// redirect decode: commit cause and branch mispredict to one fetch target
`timescale 1ns/1ps
`default_nettype none

`include "fe_defs.svh"

module fe_redirect_decode (
  input  wire fe_pkg::commit_t i_commit,
  input  wire fe_pkg::br_upd_t i_br_upd,
  input  wire fe_pkg::csr_t    i_csr,
  output fe_pkg::redirect_t    o_redirect
);

  // ========================================================================
  // commit target
  // ========================================================================

  logic [`FE_XLEN-1:0] w_commit_tgt;
  logic [`FE_XLEN-1:0] w_target;
  logic                w_br_flush;
  logic                w_trap_deleg;

  // delegation bit of the current cause
  assign w_trap_deleg = i_csr.medeleg[i_commit.cause];

  always_comb begin
    case (i_commit.cause)
      // replay past the committing instruction
      fe_pkg::SILENT_FLUSH: begin
        w_commit_tgt = i_commit.epc + `FE_XLEN'(`FE_INST_B);
      end
      // refetch the committing instruction itself
      fe_pkg::ANOTHER_FLUSH: begin
        w_commit_tgt = i_commit.epc;
      end
      fe_pkg::MRET: begin
        w_commit_tgt = i_csr.mepc;
      end
      fe_pkg::SRET: begin
        w_commit_tgt = i_csr.sepc;
      end
      // traps, supervisor vector when delegated
      fe_pkg::ECALL_U,
      fe_pkg::ECALL_S,
      fe_pkg::ECALL_M,
      fe_pkg::INST_ACC_FAULT,
      fe_pkg::ILLEGAL_INST,
      fe_pkg::LOAD_ACC_FAULT: begin
        if (w_trap_deleg) begin
          w_commit_tgt = i_csr.stvec;
        end else begin
          w_commit_tgt = i_csr.mtvec;
        end
      end
      // unlisted codes land in machine mode
      default: begin
        w_commit_tgt = i_csr.mtvec;
      end
    endcase
  end

  // ========================================================================
  // priority and output
  // ========================================================================

  // only a mispredict moves fetch
  assign w_br_flush = i_br_upd.valid & i_br_upd.mispredict;

  // commit is older than any branch in flight, so it wins
  assign w_target = i_commit.valid ? w_commit_tgt : i_br_upd.target;

  assign o_redirect.valid  = i_commit.valid | w_br_flush;
  // word aligned fetch only
  assign o_redirect.target = {w_target[`FE_XLEN-1:2], 2'b00};

endmodule

`default_nettype wire

/* hdl/fe_top.sv */
// fetch front end top: redirect decode, fetch pipe and instruction queue
`timescale 1ns/1ps
`default_nettype none

`include "fe_defs.svh"

module fe_top (
  input  wire logic                 i_clk,
  input  wire logic                 i_reset_n,
  // back end updates
  input  wire fe_pkg::commit_t      i_commit,
  input  wire fe_pkg::br_upd_t      i_br_upd,
  input  wire fe_pkg::csr_t         i_csr,
  // axi4-lite read master
  output logic                      o_arvalid,
  input  wire logic                 i_arready,
  output logic [`FE_XLEN-1:0]       o_araddr,
  output logic [2:0]                o_arprot,
  input  wire logic                 i_rvalid,
  output logic                      o_rready,
  input  wire logic [`FE_XLEN-1:0]  i_rdata,
  input  wire fe_pkg::axi_resp_e    i_rresp,
  // toward decode
  output fe_pkg::fe_inst_t          o_inst,
  output logic                      o_inst_valid,
  input  wire logic                 i_inst_ready
);

  fe_pkg::redirect_t    w_redirect;
  logic                 w_push_valid;
  fe_pkg::fe_inst_t     w_push;
  logic [`FE_CNT_W-1:0] w_iq_count;

  // ========================================================================
  // redirect cause to target, same cycle
  // ========================================================================
  fe_redirect_decode u_decode (
    .i_commit   (i_commit),
    .i_br_upd   (i_br_upd),
    .i_csr      (i_csr),
    .o_redirect (w_redirect)
  );

  // pc, bus requests, stale response filter
  fe_fetch_pipe u_fetch (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_redirect   (w_redirect),
    .i_iq_count   (w_iq_count),
    .o_arvalid    (o_arvalid),
    .i_arready    (i_arready),
    .o_araddr     (o_araddr),
    .o_arprot     (o_arprot),
    .i_rvalid     (i_rvalid),
    .o_rready     (o_rready),
    .i_rdata      (i_rdata),
    .i_rresp      (i_rresp),
    .o_push_valid (w_push_valid),
    .o_push       (w_push)
  );

  // words toward decode, emptied on any redirect
  fe_inst_queue u_queue (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (w_redirect.valid),
    .i_push_valid (w_push_valid),
    .i_push       (w_push),
    .o_count      (w_iq_count),
    .o_inst_valid (o_inst_valid),
    .o_inst       (o_inst),
    .i_inst_ready (i_inst_ready)
  );

endmodule

`default_nettype wire

/* include/fe_defs.svh */
// fetch front end widths, queue depth and reset pc macros
`ifndef FE_DEFS_SVH
`define FE_DEFS_SVH

// address and instruction word width
`define FE_XLEN 32

// bytes fetched per request, one 32-bit word
`define FE_INST_B 4

// first fetch address out of reset
`define FE_PC_RESET 32'h0000_1000

// instruction queue entries
// also bounds the number of reads in flight
`define FE_IQ_DEPTH 4

// holds a count of 0..FE_IQ_DEPTH
`define FE_CNT_W 3

// commit flush cause code
`define FE_CAUSE_W 4

`endif

/* run.sh */
#!/bin/sh
# build and run the fetch front end testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fe_tb -f verilog.f -o fe_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/fe_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
  exit 0
fi
exit 1

/* verif/fe_assertions.sv */
// bound assertions for ar stability, quiet reset outputs and pc alignment toward decode
`timescale 1ns/1ps
`default_nettype none

`include "fe_defs.svh"

module fe_assertions (
  input wire logic                 i_clk,
  input wire logic                 i_reset_n,
  input wire logic                 i_arvalid,
  input wire logic                 i_arready,
  input wire logic [`FE_XLEN-1:0]  i_araddr,
  input wire logic                 i_inst_valid,
  input wire fe_pkg::fe_inst_t     i_inst
);

  // pending read address holds until accepted
  ar_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_arvalid && !i_arready) |=> (i_arvalid && $stable(i_araddr)))
    else $error("read address channel changed before its transfer");

  // quiet bus and decode side while in reset
  reset_quiet: assert property (@(posedge i_clk)
    !i_reset_n |-> (!i_arvalid && !i_inst_valid))
    else $error("valid output high during reset");

  // entries toward decode are word aligned
  pc_align: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_inst_valid |-> (i_inst.pc[1:0] == 2'b00))
    else $error("unaligned pc toward decode");

endmodule

bind fe_top fe_assertions u_assertions (
  .i_clk        (i_clk),
  .i_reset_n    (i_reset_n),
  .i_arvalid    (o_arvalid),
  .i_arready    (i_arready),
  .i_araddr     (o_araddr),
  .i_inst_valid (o_inst_valid),
  .i_inst       (o_inst)
);

`default_nettype wire

/* verif/fe_tb.sv */
// testbench with clock, reset, axi4-lite memory model, checks and directed tests
`timescale 1ns/1ps
`default_nettype none

`include "fe_defs.svh"

module fe_tb;

  localparam logic [31:0] DATA_PAT = 32'hA5A5_5A5A;
  // the one address that answers slverr
  localparam logic [31:0] ERR_ADDR = 32'h0000_3000;
  localparam int          TIMEOUT  = 200;

  logic                  i_clk;
  logic                  i_reset_n;
  fe_pkg::commit_t       i_commit;
  fe_pkg::br_upd_t       i_br_upd;
  fe_pkg::csr_t          i_csr;
  logic                  o_arvalid;
  logic                  i_arready;
  logic [`FE_XLEN-1:0]   o_araddr;
  logic [2:0]            o_arprot;
  logic                  i_rvalid;
  logic                  o_rready;
  logic [`FE_XLEN-1:0]   i_rdata;
  fe_pkg::axi_resp_e     i_rresp;
  fe_pkg::fe_inst_t      o_inst;
  logic                  o_inst_valid;
  logic                  i_inst_ready;

  integer seed = 32'h06de4317;
  int     errors = 0;
  int     checks = 0;

  fe_top uut (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_commit     (i_commit),
    .i_br_upd     (i_br_upd),
    .i_csr        (i_csr),
    .o_arvalid    (o_arvalid),
    .i_arready    (i_arready),
    .o_araddr     (o_araddr),
    .o_arprot     (o_arprot),
    .i_rvalid     (i_rvalid),
    .o_rready     (o_rready),
    .i_rdata      (i_rdata),
    .i_rresp      (i_rresp),
    .o_inst       (o_inst),
    .o_inst_valid (o_inst_valid),
    .i_inst_ready (i_inst_ready)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // ==========================================================================
  // axi4-lite read slave with in-order answers and random stalls
  // ==========================================================================
  initial begin : axi_mem
    logic [31:0] rd_q [$];
    logic        ar_taken;
    logic        r_taken;
    logic [31:0] ar_addr;
    logic [31:0] rsp_addr;
    i_arready = 1'b0;
    i_rvalid  = 1'b0;
    i_rdata   = '0;
    i_rresp   = fe_pkg::OKAY;
    forever begin
      // bus is stable mid cycle
      @(negedge i_clk);
      ar_taken = o_arvalid & i_arready;
      r_taken  = i_rvalid & o_rready;
      ar_addr  = o_araddr;
      // unprivileged secure instruction access
      if (ar_taken) begin
        check_val("o_arprot", 32'h0000_0004, 32'(o_arprot));
      end
      // fetch never stalls a read response
      if (i_rvalid) begin
        check_val("o_rready", 32'h0000_0001, 32'(o_rready));
      end
      @(posedge i_clk);
      #1;
      if (ar_taken) begin
        rd_q.push_back(ar_addr);
      end
      if (r_taken) begin
        i_rvalid = 1'b0;
      end
      if (!i_rvalid && rd_q.size() > 0 && ($random(seed) & 3) != 0) begin
        rsp_addr = rd_q.pop_front();
        i_rvalid = 1'b1;
        i_rdata  = rsp_addr ^ DATA_PAT;
        i_rresp  = (rsp_addr == ERR_ADDR) ? fe_pkg::SLVERR : fe_pkg::OKAY;
      end
      i_arready = (($random(seed) & 3) != 0);
    end
  end

  // ==========================================================================
  // helpers
  // ==========================================================================
  task automatic end_run;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error at %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // expected entry follows from the memory rule and the slverr address
  task automatic check_inst(input string name, input logic [31:0] pc, input fe_pkg::fe_inst_t e);
    check_val({name, " o_inst.pc"}, pc, e.pc);
    check_val({name, " o_inst.inst"}, pc ^ DATA_PAT, e.inst);
    check_val({name, " o_inst.fault"}, 32'(pc == ERR_ADDR), 32'(e.fault));
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge i_clk);
      #1;
    end
  endtask

  // take one entry from the queue between two edges
  task automatic pop_inst(output fe_pkg::fe_inst_t e);
    int n;
    n = 0;
    e = '0;
    i_inst_ready = 1'b1;
    @(negedge i_clk);
    while (!o_inst_valid && n < TIMEOUT) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_inst_valid) begin
      errors++;
      $display("timeout at %0t ns: no entry toward decode in %0d cycles", $time, TIMEOUT);
      end_run();
    end else begin
      e = o_inst;
      // handshake lands at the next edge
      @(posedge i_clk);
      #1;
      i_inst_ready = 1'b0;
    end
  endtask

  task automatic check_stream(input string name, input logic [31:0] start, input int n);
    fe_pkg::fe_inst_t e;
    int k;
    for (k = 0; k < n; k++) begin
      pop_inst(e);
      check_inst(name, start + 32'(k * `FE_INST_B), e);
    end
  endtask

  function automatic fe_pkg::commit_t make_commit(input fe_pkg::flush_cause_e cause,
                                                  input logic [31:0] epc);
    fe_pkg::commit_t c;
    c.valid = 1'b1;
    c.cause = cause;
    c.epc   = epc;
    return c;
  endfunction

  function automatic fe_pkg::br_upd_t make_branch(input logic [31:0] target);
    fe_pkg::br_upd_t b;
    b.valid      = 1'b1;
    b.mispredict = 1'b1;
    b.target     = target;
    return b;
  endfunction

  // one cycle of commit and branch update while decode is held off
  task automatic apply_redirect(input fe_pkg::commit_t c, input fe_pkg::br_upd_t b);
    i_commit = c;
    i_br_upd = b;
    @(posedge i_clk);
    #1;
    i_commit = '0;
    i_br_upd = '0;
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================
  task automatic sequential_fetch;
    check_stream("sequential", `FE_PC_RESET, 8);
  endtask

  task automatic backpressure_order;
    fe_pkg::fe_inst_t e;
    logic [31:0] pc;
    int k;
    int span;
    // picks up right after the sequential words
    pc = `FE_PC_RESET + 32'(8 * `FE_INST_B);
    for (k = 0; k < 24; k++) begin
      span = $unsigned($random(seed)) % 6;
      idle(span);
      pop_inst(e);
      check_inst("backpressure", pc, e);
      pc = pc + 32'(`FE_INST_B);
    end
  endtask

  task automatic branch_redirect;
    idle(3);
    apply_redirect('0, make_branch(32'h0000_2000));
    check_stream("branch", 32'h0000_2000, 4);
  endtask

  task automatic commit_causes;
    i_csr.mtvec   = 32'h0000_4000;
    i_csr.stvec   = 32'h0000_5000;
    // low bits of a target never reach the bus
    i_csr.mepc    = 32'h0000_6003;
    i_csr.sepc    = 32'h0000_7000;
    i_csr.medeleg = '0;
    apply_redirect(make_commit(fe_pkg::SILENT_FLUSH, 32'h0000_2400), '0);
    check_stream("silent flush", 32'h0000_2404, 3);
    apply_redirect(make_commit(fe_pkg::ANOTHER_FLUSH, 32'h0000_2800), '0);
    check_stream("another flush", 32'h0000_2800, 3);
    apply_redirect(make_commit(fe_pkg::MRET, 32'h0000_2900), '0);
    check_stream("mret", 32'h0000_6000, 3);
    // delegated ecall goes to the supervisor vector
    i_csr.medeleg = 32'd1 << fe_pkg::ECALL_U;
    apply_redirect(make_commit(fe_pkg::ECALL_U, 32'h0000_2a00), '0);
    check_stream("ecall deleg", 32'h0000_5000, 3);
    i_csr.medeleg = '0;
    apply_redirect(make_commit(fe_pkg::ECALL_U, 32'h0000_2a00), '0);
    check_stream("ecall machine", 32'h0000_4000, 3);
    // commit beats a branch in the same cycle
    apply_redirect(make_commit(fe_pkg::ANOTHER_FLUSH, 32'h0000_2c00),
                   make_branch(32'h0000_2000));
    check_stream("commit over branch", 32'h0000_2c00, 3);
  endtask

  task automatic access_fault;
    apply_redirect('0, make_branch(ERR_ADDR));
    check_stream("access fault", ERR_ADDR, 2);
  endtask

  initial begin
    i_reset_n    = 1'b1;
    i_commit     = '0;
    i_br_upd     = '0;
    i_csr        = '0;
    i_inst_ready = 1'b0;
    #1;
    i_reset_n = 1'b0;
    repeat (16) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    sequential_fetch();
    backpressure_order();
    branch_redirect();
    commit_causes();
    access_fault();
    end_run();
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
hdl/fe_pkg.sv
hdl/fe_redirect_decode.sv
hdl/fe_fetch_pipe.sv
hdl/fe_inst_queue.sv
hdl/fe_top.sv
verif/fe_assertions.sv
verif/fe_tb.sv
